// File: src/traffic_defs.svh
`ifndef TRAFFIC_DEFS_SVH
`define TRAFFIC_DEFS_SVH

// One tick stands for 0.1 s of real time.

//////////////////////////////
// Phase lengths in ticks
//////////////////////////////

`define TICKS_LONG  450 // Main green, 45 s.
`define TICKS_CLEAR 50  // Yellow clearance, 5 s.
`define TICKS_TURN  250 // Left turns and side green, 25 s.

//////////////////////////////
// Blink and sizing
//////////////////////////////

`define TICKS_FLASH 5 // Ticks between yellow toggles.

// Must hold the longest phase length.
`define TICK_WIDTH 9

`define LAMP_COUNT 16 // Eight lamp kinds times two approaches.

`endif

// File: src/traffic_pkg.sv
`default_nettype none

package traffic_pkg;

    // Twelve phases of the junction cycle, in running order.
    typedef enum logic [3:0] {
        PH_MAIN_GREEN,      // Long main road green.
        PH_MAIN_CLEAR,      // Main yellow.
        PH_MAIN_LEFT_1,     // Protected left, main approach 1.
        PH_MAIN_LEFT_CLEAR,
        PH_MAIN_LEFT_2,     // Protected left, main approach 2.
        PH_SIDE_PREP,       // Side yellow before side green.
        PH_SIDE_GREEN,
        PH_SIDE_CLEAR,
        PH_SIDE_LEFT_1,     // Protected left, side approach 1.
        PH_SIDE_LEFT_CLEAR,
        PH_SIDE_LEFT_2,     // Protected left, side approach 2.
        PH_RETURN_CLEAR     // Last clearance before main green.
    } phase_t;

    // Length class of a phase.
    typedef enum logic [1:0] {
        SPAN_LONG,  // Main green length.
        SPAN_CLEAR, // Clearance length.
        SPAN_TURN   // Turn and side green length.
    } span_t;

    // One bit per lamp. Bit 0 is approach 1, bit 1 is approach 2.
    typedef struct packed {
        logic [1:0] main_red;
        logic [1:0] main_yellow;
        logic [1:0] main_green;
        logic [1:0] main_left;
        logic [1:0] side_red;
        logic [1:0] side_yellow;
        logic [1:0] side_green;
        logic [1:0] side_left;
    } lamps_t;

endpackage

`default_nettype wire

// File: src/phase_timer.sv
`default_nettype none

`include "traffic_defs.svh"

module phase_timer (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               timer_req,  // Held high for the whole phase.
    input  traffic_pkg::span_t timer_span, // Stable while timer_req is high.
    output logic               timer_ack   // Terminal count reached.
);

    localparam int unsigned TW = `TICK_WIDTH;

    logic [TW-1:0] count;      // Ticks elapsed in this phase.
    logic [TW-1:0] span_ticks; // Length of the requested span.
    logic [TW-1:0] last_count; // Count value on the ack edge.

    //////////////////////////////
    // Span decode
    //////////////////////////////

    always_comb
    begin
        case (timer_span)
            traffic_pkg::SPAN_LONG:  span_ticks = TW'(`TICKS_LONG);
            traffic_pkg::SPAN_CLEAR: span_ticks = TW'(`TICKS_CLEAR);
            default:                 span_ticks = TW'(`TICKS_TURN); // Turn and spare code.
        endcase
    end

    assign last_count = span_ticks - 1'b1; // Ack lands span_ticks edges after req.

    //////////////////////////////
    // Count and ack
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            count     <= '0;
            timer_ack <= 1'b0;
        end
        else if (!timer_req)
        begin
            // Idle or aborted request.
            count     <= '0;
            timer_ack <= 1'b0;
        end
        else if (!timer_ack)
        begin
            count <= count + 1'b1; // Running.
            if (count == last_count)
            begin
                timer_ack <= 1'b1; // Done. Count stays put from here.
            end
        end
    end

    // Ack only answers a live request.
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!reset_n)
        $rose(timer_ack) |-> $past(timer_req)
    );

endmodule

`default_nettype wire

// File: src/phase_sequencer.sv
`default_nettype none

module phase_sequencer (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                blink,      // Blink mode request.
    input  logic                timer_ack,
    output logic                timer_req,
    output traffic_pkg::span_t  timer_span,
    output traffic_pkg::phase_t phase,      // Current phase.
    output logic                flash_mode  // Lamps flash yellow.
);

    traffic_pkg::phase_t next_phase; // Successor in the cycle.
    logic                advance;    // Phase finished this cycle.
    logic                launch;     // Timer is free for a new request.
    logic                start_wait; // Spacer cycle after reset or blink exit.

    //////////////////////////////
    // Cycle order and span
    //////////////////////////////

    always_comb
    begin
        if (phase == traffic_pkg::PH_RETURN_CLEAR)
        begin
            next_phase = traffic_pkg::PH_MAIN_GREEN; // Wrap.
        end
        else
        begin
            next_phase = traffic_pkg::phase_t'(phase + 1'b1);
        end
    end

    // Long main green, clearance on odd phases, turn length elsewhere.
    always_comb
    begin
        if (phase == traffic_pkg::PH_MAIN_GREEN)
        begin
            timer_span = traffic_pkg::SPAN_LONG;
        end
        else if (phase[0])
        begin
            timer_span = traffic_pkg::SPAN_CLEAR;
        end
        else
        begin
            timer_span = traffic_pkg::SPAN_TURN;
        end
    end

    assign advance = timer_req & timer_ack;
    // Ack must be low again before the next request.
    assign launch  = !timer_req && !timer_ack && !start_wait;

    //////////////////////////////
    // Phase and handshake state
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            phase      <= traffic_pkg::PH_MAIN_GREEN;
            flash_mode <= 1'b0;
            timer_req  <= 1'b0;
            start_wait <= 1'b1; // Gives the first main green its full hold.
        end
        else if (blink)
        begin
            // Blink override. Abort the running phase.
            flash_mode <= 1'b1;
            timer_req  <= 1'b0;
            start_wait <= 1'b0;
        end
        else if (flash_mode)
        begin
            flash_mode <= 1'b0; // Leave blink and restart the cycle.
            phase      <= traffic_pkg::PH_MAIN_GREEN;
            start_wait <= 1'b1;
        end
        else
        begin
            start_wait <= 1'b0;
            if (advance)
            begin
                phase     <= next_phase; // Step and release the timer together.
                timer_req <= 1'b0;
            end
            else if (launch)
            begin
                timer_req <= 1'b1; // Start timing the current phase.
            end
        end
    end

    // Four-phase rule. No new request before the old ack is gone.
    a_req_after_ack_low: assert property (
        @(posedge clk) disable iff (!reset_n)
        $rose(timer_req) |-> !$past(timer_ack)
    );

    // Outside blink the phase moves only on a timer ack.
    a_phase_needs_ack: assert property (
        @(posedge clk) disable iff (!reset_n)
        $changed(phase) |-> ($past(timer_ack) || $past(flash_mode))
    );

endmodule

`default_nettype wire

// File: src/lamp_driver.sv
`default_nettype none

`include "traffic_defs.svh"

module lamp_driver (
    input  logic                clk,
    input  logic                reset_n,
    input  traffic_pkg::phase_t phase,
    input  logic                flash_mode,
    output traffic_pkg::lamps_t lamps      // Registered lamp drive.
);

    localparam int unsigned FLASH_W = $clog2(`TICKS_FLASH + 1);
    localparam logic [FLASH_W-1:0] FLASH_LAST = FLASH_W'(`TICKS_FLASH - 1);
    localparam traffic_pkg::lamps_t LAMPS_OFF =
        traffic_pkg::lamps_t'({`LAMP_COUNT{1'b0}});

    logic [FLASH_W-1:0]  flash_cnt;   // Ticks since the last toggle.
    logic                flash_on;    // Current yellow state in blink.
    traffic_pkg::lamps_t flash_lamps; // Blink pattern.

    //////////////////////////////
    // Phase table
    //////////////////////////////

    function automatic traffic_pkg::lamps_t phase_lamps(input traffic_pkg::phase_t ph);
        traffic_pkg::lamps_t l;
        l = LAMPS_OFF;
        case (ph)
            traffic_pkg::PH_MAIN_GREEN:
            begin
                l.main_green = 2'b11;
                l.side_red   = 2'b11;
            end
            traffic_pkg::PH_MAIN_CLEAR:
            begin
                l.main_yellow = 2'b11;
                l.side_red    = 2'b11;
            end
            traffic_pkg::PH_MAIN_LEFT_1:
            begin
                l.main_red  = 2'b11;
                l.main_left = 2'b01; // Approach 1 turns.
                l.side_red  = 2'b11;
            end
            traffic_pkg::PH_MAIN_LEFT_CLEAR:
            begin
                l.main_red    = 2'b11;
                l.main_yellow = 2'b11;
                l.side_red    = 2'b11;
            end
            traffic_pkg::PH_MAIN_LEFT_2:
            begin
                l.main_red  = 2'b11;
                l.main_left = 2'b10; // Approach 2 turns.
                l.side_red  = 2'b11;
            end
            traffic_pkg::PH_SIDE_PREP:
            begin
                l.main_red    = 2'b11;
                l.main_yellow = 2'b10;
                l.side_yellow = 2'b11;
            end
            traffic_pkg::PH_SIDE_GREEN:
            begin
                l.main_red   = 2'b11;
                l.side_green = 2'b11;
            end
            traffic_pkg::PH_SIDE_CLEAR:
            begin
                l.main_red    = 2'b11;
                l.side_yellow = 2'b11;
            end
            traffic_pkg::PH_SIDE_LEFT_1:
            begin
                l.main_red  = 2'b11;
                l.side_red  = 2'b11;
                l.side_left = 2'b01;
            end
            traffic_pkg::PH_SIDE_LEFT_CLEAR:
            begin
                l.main_red    = 2'b11;
                l.side_red    = 2'b11;
                l.side_yellow = 2'b10; // Only side yellow 2 is lit.
            end
            traffic_pkg::PH_SIDE_LEFT_2:
            begin
                l.main_red  = 2'b11;
                l.side_red  = 2'b11;
                l.side_left = 2'b10;
            end
            traffic_pkg::PH_RETURN_CLEAR:
            begin
                l.main_yellow = 2'b11;
                l.side_red    = 2'b11;
                l.side_yellow = 2'b10;
            end
            default: l = LAMPS_OFF; // Spare codes stay dark.
        endcase
        return l;
    endfunction

    //////////////////////////////
    // Blink pattern and register
    //////////////////////////////

    always_comb
    begin
        flash_lamps             = LAMPS_OFF; // All four yellows, nothing else.
        flash_lamps.main_yellow = {2{flash_on}};
        flash_lamps.side_yellow = {2{flash_on}};
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            lamps     <= LAMPS_OFF; // Dark after reset.
            flash_cnt <= '0;
            flash_on  <= 1'b0;
        end
        else if (flash_mode)
        begin
            lamps <= flash_lamps;
            if (flash_cnt == FLASH_LAST)
            begin
                flash_cnt <= '0;
                flash_on  <= ~flash_on; // Toggle the yellows.
            end
            else
            begin
                flash_cnt <= flash_cnt + 1'b1;
            end
        end
        else
        begin
            lamps     <= phase_lamps(phase);
            flash_cnt <= '0; // Next blink starts dark.
            flash_on  <= 1'b0;
        end
    end

    // Conflicting greens.
    a_greens_exclusive: assert property (
        @(posedge clk) disable iff (!reset_n)
        !((|lamps.main_green) && (|lamps.side_green))
    );

endmodule

`default_nettype wire

// File: src/traffic_controller.sv
`default_nettype none

module traffic_controller (
    input  logic clk,
    input  logic reset_n,
    input  logic blink,         // High forces yellow flash.
    output logic main_red_1,
    output logic main_red_2,
    output logic main_yellow_1,
    output logic main_yellow_2,
    output logic main_green_1,
    output logic main_green_2,
    output logic main_left_1,
    output logic main_left_2,
    output logic side_red_1,
    output logic side_red_2,
    output logic side_yellow_1,
    output logic side_yellow_2,
    output logic side_green_1,
    output logic side_green_2,
    output logic side_left_1,
    output logic side_left_2
);

    logic                timer_req;  // Sequencer to timer.
    logic                timer_ack;  // Timer to sequencer.
    traffic_pkg::span_t  timer_span;
    traffic_pkg::phase_t phase;
    logic                flash_mode;
    traffic_pkg::lamps_t lamps;      // Registered lamp bundle.

    //////////////////////////////
    // Instances
    //////////////////////////////

    phase_sequencer u_sequencer (
        .clk        (clk),
        .reset_n    (reset_n),
        .blink      (blink),
        .timer_ack  (timer_ack),
        .timer_req  (timer_req),
        .timer_span (timer_span),
        .phase      (phase),
        .flash_mode (flash_mode)
    );

    phase_timer u_timer (
        .clk        (clk),
        .reset_n    (reset_n),
        .timer_req  (timer_req),
        .timer_span (timer_span),
        .timer_ack  (timer_ack)
    );

    lamp_driver u_lamps (
        .clk        (clk),
        .reset_n    (reset_n),
        .phase      (phase),
        .flash_mode (flash_mode),
        .lamps      (lamps)
    );

    //////////////////////////////
    // Lamp outputs
    //////////////////////////////

    assign main_red_1    = lamps.main_red[0];
    assign main_red_2    = lamps.main_red[1];
    assign main_yellow_1 = lamps.main_yellow[0];
    assign main_yellow_2 = lamps.main_yellow[1];
    assign main_green_1  = lamps.main_green[0];
    assign main_green_2  = lamps.main_green[1];
    assign main_left_1   = lamps.main_left[0];  // Main road turns.
    assign main_left_2   = lamps.main_left[1];
    assign side_red_1    = lamps.side_red[0];
    assign side_red_2    = lamps.side_red[1];
    assign side_yellow_1 = lamps.side_yellow[0];
    assign side_yellow_2 = lamps.side_yellow[1];
    assign side_green_1  = lamps.side_green[0];
    assign side_green_2  = lamps.side_green[1];
    assign side_left_1   = lamps.side_left[0];  // Side road turns.
    assign side_left_2   = lamps.side_left[1];

endmodule

`default_nettype wire

// File: bench/tb_traffic_controller.sv
`default_nettype none

`include "traffic_defs.svh"

module tb_traffic_controller;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned PHASES      = 12;
    localparam int unsigned DATA_WORDS  = 2 * PHASES + 2; // Phase rows plus blink row.
    localparam logic [15:0] YELLOW_MASK = 16'h3030;       // All four yellow lamps.

    logic clk = 1'b0; // Starts low.
    logic reset_n;
    logic blink;
    logic main_red_1;
    logic main_red_2;
    logic main_yellow_1;
    logic main_yellow_2;
    logic main_green_1;
    logic main_green_2;
    logic main_left_1;
    logic main_left_2;
    logic side_red_1;
    logic side_red_2;
    logic side_yellow_1;
    logic side_yellow_2;
    logic side_green_1;
    logic side_green_2;
    logic side_left_1;
    logic side_left_2;

    logic [31:0] testdata [0:DATA_WORDS-1]; // Pattern and hold per phase, then blink.
    logic [15:0] lamps;                     // Lamp outputs packed as in the data file.
    int unsigned limit_cycles = 0;          // Watchdog budget in cycles. Zero until data is read.

    always
    begin
        #10 clk = ~clk; // 20 ns period.
    end

    traffic_controller u_dut (.*);

    assign lamps = {main_red_2,    main_red_1,    main_yellow_2, main_yellow_1,
                    main_green_2,  main_green_1,  main_left_2,   main_left_1,
                    side_red_2,    side_red_1,    side_yellow_2, side_yellow_1,
                    side_green_2,  side_green_1,  side_left_2,   side_left_1};

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h",
                     $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Called on the first sample of a phase. Returns on the first sample of the next one.
    task automatic measure_phase(input int unsigned idx);
        logic [15:0] pattern;
        int unsigned hold_len;
        int unsigned held;
        pattern  = testdata[2*idx][15:0];
        hold_len = testdata[2*idx+1];
        expect_equal($sformatf("lamps of phase %0d", idx), {16'h0, lamps}, {16'h0, pattern});
        held = 1;
        @(negedge clk);
        while (lamps == pattern && held <= hold_len)
        begin
            held++; // A stuck phase stops one past hold_len.
            @(negedge clk);
        end
        expect_equal($sformatf("hold of phase %0d", idx), held, hold_len);
    endtask

    // Main green must show up within max_cycles samples.
    task automatic await_main_green(input int unsigned max_cycles, input string what);
        int unsigned waited;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (lamps != testdata[0][15:0] && waited < max_cycles);
        expect_equal(what, {16'h0, lamps}, testdata[0]);
    endtask

    //////////////////////////////
    // Monitors
    //////////////////////////////

    // Conflicting greens on every cycle.
    always @(negedge clk)
    begin
        expect_equal("main and side green together",
                     {31'h0, (main_green_1 | main_green_2) & (side_green_1 | side_green_2)},
                     32'h0);
    end

    initial
    begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run hung", limit_cycles);
        $display("TEST FAILED");
        $fatal(1);
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial
    begin
        int unsigned i;
        int unsigned c;
        int unsigned total;
        logic [15:0] yellow_exp;
        reset_n = 1'b0;
        blink   = 1'b0;

        $readmemh("bench/traffic_testdata.txt", testdata);
        if ($isunknown(testdata[1]) || $isunknown(testdata[DATA_WORDS-1])
            || testdata[1] == 32'h0 || testdata[DATA_WORDS-1] == 32'h0)
        begin
            $display("Test data file is missing or incomplete");
            $display("TEST FAILED");
            $fatal(1);
        end

        total = 4; // Reset cycles.
        for (i = 0; i < PHASES; i++)
        begin
            total += 2 * testdata[2*i+1]; // Two full cycles.
        end
        total += testdata[2*PHASES] + testdata[2*PHASES+1] + testdata[1] + 8;
        limit_cycles = 2 * total;

        // Dark while in reset.
        for (i = 0; i < 4; i++)
        begin
            @(negedge clk);
            expect_equal("lamps in reset", {16'h0, lamps}, 32'h0);
        end
        @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        expect_equal("lamps after reset", {16'h0, lamps}, 32'h0); // Still dark.
        await_main_green(2, "first pattern after reset");

        // Two full cycles with wrap.
        for (i = 0; i < 2 * PHASES; i++)
        begin
            measure_phase(i % PHASES);
        end
        expect_equal("lamps after wrap", {16'h0, lamps}, testdata[0]);

        //////////////////////////////
        // Blink scenario
        //////////////////////////////

        repeat (testdata[2*PHASES]) @(posedge clk);
        blink <= 1'b1;
        for (c = 1; c <= testdata[2*PHASES+1]; c++)
        begin
            @(negedge clk);
            if (c <= 2)
            begin
                // Blink still passing through sequencer and lamp register.
                expect_equal("lamps before blink takes hold", {16'h0, lamps}, testdata[0]);
            end
            else
            begin
                yellow_exp = (((c - 3) / `TICKS_FLASH) % 2 == 1) ? YELLOW_MASK : 16'h0000;
                expect_equal("non-yellow lamps in blink",
                             {16'h0, lamps & ~YELLOW_MASK}, 32'h0);
                expect_equal("yellow lamps in blink",
                             {16'h0, lamps & YELLOW_MASK}, {16'h0, yellow_exp});
            end
        end
        @(posedge clk);
        blink <= 1'b0;
        await_main_green(3, "first pattern after blink");
        measure_phase(0); // Full length shows the timer restarted clean.
        expect_equal("lamps after blink restart", {16'h0, lamps}, testdata[2]);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/traffic_testdata.txt
// Columns: lamp pattern, hold cycles (tick count plus 3). One row per phase 0 to 11.
// Pattern bits 15 to 0: main red 2 1, main yellow 2 1, main green 2 1, main left 2 1,
// side red 2 1, side yellow 2 1, side green 2 1, side left 2 1.
0cc0 01c5 // Main green.
30c0 0035 // Main clear.
c1c0 00fd // Main left 1.
f0c0 0035 // Main left clear.
c2c0 00fd // Main left 2.
e030 0035 // Side prep.
c00c 00fd // Side green.
c030 0035 // Side clear.
c0c1 00fd // Side left 1.
c0e0 0035 // Side left clear.
c0c2 00fd // Side left 2.
30e0 0035 // Return clear.
// Blink row: cycles into main green before blink rises, cycles blink stays high.
0078 0028

// File: vlog.f
+incdir+src
src/traffic_pkg.sv
src/phase_timer.sv
src/phase_sequencer.sv
src/lamp_driver.sv
src/traffic_controller.sv
bench/tb_traffic_controller.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_traffic_controller -f vlog.f -o tb_traffic_controller
./obj_dir/tb_traffic_controller
